/* hw/ds_branch_unit.sv */
// ds_branch_unit, branch compare and jump target generation
`timescale 1ns/1ps

module ds_branch_unit (
  input  ds_pkg::jump_e    i_jump,
  input  ds_pkg::br_func_e i_br_func,
  input  ds_pkg::xlen_t    i_rs1_data,
  input  ds_pkg::xlen_t    i_rs2_data,
  input  ds_pkg::xlen_t    i_pc,
  input  ds_pkg::xlen_t    i_imm,
  output logic             o_taken,
  output ds_pkg::xlen_t    o_target
);

  import ds_pkg::*;

  logic  cond;
  xlen_t pc_rel;
  xlen_t reg_rel;

  assign pc_rel  = i_pc + i_imm;
  assign reg_rel = i_rs1_data + i_imm;

  always_comb begin
    case (i_br_func)
      BR_EQ:   cond = (i_rs1_data == i_rs2_data);
      BR_NE:   cond = (i_rs1_data != i_rs2_data);
      BR_LT:   cond = ($signed(i_rs1_data) < $signed(i_rs2_data));
      BR_GE:   cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      BR_LTU:  cond = (i_rs1_data < i_rs2_data);
      BR_GEU:  cond = (i_rs1_data >= i_rs2_data);
      default: cond = 1'b0;  // funct3 2 and 3 never branch
    endcase
  end

  always_comb begin
    case (i_jump)
      JUMP_BRANCH: o_taken = cond;
      JUMP_JAL:    o_taken = 1'b1;
      JUMP_JALR:   o_taken = 1'b1;
      default:     o_taken = 1'b0;
    endcase
  end

  // jalr target has bit 0 cleared
  assign o_target = (i_jump == JUMP_JALR) ? {reg_rel[$bits(xlen_t)-1:1], 1'b0} : pc_rel;

endmodule

/* hw/ds_config.svh */
// width and size macros for the decode stage
`ifndef DS_CONFIG_SVH
`define DS_CONFIG_SVH

// data word and pc width
`define DS_XLEN 64

// instruction width
`define DS_INST_W 32

// register file geometry
`define DS_GPR_ADDR_W 5
`define DS_GPR_NUM 32

`define DS_PC_STEP 4  // sequential pc increment, also the link offset

`endif

/* hw/ds_decoder.sv */
// ds_decoder, field extraction, immediate generation and control decode for RV64I
`timescale 1ns/1ps
`include "ds_config.svh"

module ds_decoder (
  input  ds_pkg::inst_t     i_inst,
  output ds_pkg::gpr_addr_t o_rs1,
  output ds_pkg::gpr_addr_t o_rs2,
  output ds_pkg::gpr_addr_t o_rd,
  output logic              o_uses_rs1,
  output logic              o_uses_rs2,
  output ds_pkg::xlen_t     o_imm,
  output ds_pkg::jump_e     o_jump,
  output ds_pkg::br_func_e  o_br_func,
  output ds_pkg::alu_op_e   o_alu_op,
  output ds_pkg::src1_sel_e o_src1_sel,
  output ds_pkg::src2_sel_e o_src2_sel,
  output logic              o_word_op,
  output logic              o_gpr_wen,
  output logic              o_mem_ren,
  output logic              o_mem_wen,
  output ds_pkg::mem_op_e   o_mem_op,
  output logic              o_invalid
);

  import ds_pkg::*;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM_W  = 7'b0011011;
  localparam logic [6:0] OP_REG_W  = 7'b0111011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;     // inst[30], sub and sra select
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;

  // alu op from funct3, sub only exists in the register forms
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic f_alt,
                                      input logic is_reg);
    alu_op_e op;
    case (f3)
      3'd0:    op = (is_reg && f_alt) ? ALU_SUB : ALU_ADD;
      3'd1:    op = ALU_SLL;
      3'd2:    op = ALU_SLT;
      3'd3:    op = ALU_SLTU;
      3'd4:    op = ALU_XOR;
      3'd5:    op = f_alt ? ALU_SRA : ALU_SRL;
      3'd6:    op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign alt    = i_inst[30];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];
  assign o_rd   = o_gpr_wen ? gpr_addr_t'(i_inst[11:7]) : '0;  // no rd for st, br, invalid

  assign imm_i = {{(`DS_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`DS_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`DS_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(`DS_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`DS_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  assign o_br_func = br_func_e'(funct3);
  assign o_mem_op  = mem_op_e'(funct3);

  always_comb begin
    o_uses_rs1 = 1'b0;
    o_uses_rs2 = 1'b0;
    o_imm      = '0;
    o_jump     = JUMP_NONE;
    o_alu_op   = ALU_ADD;
    o_src1_sel = SRC1_RS1;
    o_src2_sel = SRC2_RS2;
    o_word_op  = 1'b0;
    o_gpr_wen  = 1'b0;
    o_mem_ren  = 1'b0;
    o_mem_wen  = 1'b0;
    o_invalid  = 1'b0;
    case (opcode)
      OP_LUI: begin
        o_imm      = imm_u;
        o_alu_op   = ALU_PASS_B;
        o_src2_sel = SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      OP_AUIPC: begin
        o_imm      = imm_u;
        o_src1_sel = SRC1_PC;
        o_src2_sel = SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      OP_JAL: begin  // alu forms the link value pc + 4
        o_imm      = imm_j;
        o_jump     = JUMP_JAL;
        o_src1_sel = SRC1_PC;
        o_src2_sel = SRC2_PC_STEP;
        o_gpr_wen  = 1'b1;
      end
      OP_JALR: begin
        o_imm      = imm_i;
        o_jump     = JUMP_JALR;
        o_uses_rs1 = 1'b1;
        o_src1_sel = SRC1_PC;
        o_src2_sel = SRC2_PC_STEP;
        o_gpr_wen  = 1'b1;
      end
      OP_BRANCH: begin
        o_imm      = imm_b;
        o_jump     = JUMP_BRANCH;
        o_uses_rs1 = 1'b1;
        o_uses_rs2 = 1'b1;
      end
      OP_LOAD: begin
        o_imm      = imm_i;
        o_uses_rs1 = 1'b1;
        o_src2_sel = SRC2_IMM;
        o_gpr_wen  = 1'b1;
        o_mem_ren  = 1'b1;
      end
      OP_STORE: begin
        o_imm      = imm_s;
        o_uses_rs1 = 1'b1;
        o_uses_rs2 = 1'b1;   // store data
        o_src2_sel = SRC2_IMM;
        o_mem_wen  = 1'b1;
      end
      OP_IMM, OP_IMM_W: begin
        o_imm      = imm_i;
        o_uses_rs1 = 1'b1;
        o_alu_op   = alu_sel(funct3, alt, 1'b0);
        o_src2_sel = SRC2_IMM;
        o_word_op  = (opcode == OP_IMM_W);
        o_gpr_wen  = 1'b1;
      end
      OP_REG, OP_REG_W: begin
        o_uses_rs1 = 1'b1;
        o_uses_rs2 = 1'b1;
        o_alu_op   = alu_sel(funct3, alt, 1'b1);
        o_word_op  = (opcode == OP_REG_W);
        o_gpr_wen  = 1'b1;
      end
      default: o_invalid = 1'b1;
    endcase
  end

endmodule

/* hw/ds_fetch_latch.sv */
// ds_fetch_latch, one-entry input register for instruction and pc from fetch
`timescale 1ns/1ps

module ds_fetch_latch (
  input  logic          i_clk,
  input  logic          i_reset,
  input  logic          i_fs_valid,
  input  logic          i_fs_ready,
  input  ds_pkg::inst_t i_fs_inst,
  input  ds_pkg::xlen_t i_fs_pc,
  output logic          o_held_valid,
  output ds_pkg::inst_t o_inst,
  output ds_pkg::xlen_t o_pc
);

  import ds_pkg::*;

  // valid follows fetch whenever the stage can take a new entry
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_held_valid <= 1'b0;
    end else if (i_fs_ready) begin
      o_held_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && i_fs_ready) begin  // fetch transfer
      o_inst <= i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

endmodule

/* hw/ds_gpr_file.sv */
// ds_gpr_file, 32 x 64-bit general registers, two read ports and one write port
`timescale 1ns/1ps
`include "ds_config.svh"

module ds_gpr_file (
  input  logic              i_clk,
  input  ds_pkg::gpr_addr_t i_raddr1,
  input  ds_pkg::gpr_addr_t i_raddr2,
  input  logic              i_wen,
  input  ds_pkg::gpr_addr_t i_waddr,
  input  ds_pkg::xlen_t     i_wdata,
  output ds_pkg::xlen_t     o_rdata1,
  output ds_pkg::xlen_t     o_rdata2
);

  import ds_pkg::*;

  xlen_t regs [1:`DS_GPR_NUM-1];  // x0 has no storage

  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // same-cycle write is not visible until the edge
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* hw/ds_issue_ctrl.sv */
// ds_issue_ctrl, load-use stall, stage handshakes and redirect qualifier
`timescale 1ns/1ps

module ds_issue_ctrl (
  input  logic i_held_valid,
  input  logic i_es_ready,
  input  logic i_es_load,
  input  logic i_rs1_es_hit,
  input  logic i_rs2_es_hit,
  input  logic i_uses_rs1,
  input  logic i_uses_rs2,
  input  logic i_taken,
  output logic o_fs_ready,
  output logic o_es_valid,
  output logic o_br_taken
);

  logic load_stall;
  logic ready_go;

  // load result only exists once the load reaches mem
  assign load_stall = i_es_load &&
                      ((i_uses_rs1 && i_rs1_es_hit) || (i_uses_rs2 && i_rs2_es_hit));
  assign ready_go   = ~load_stall;

  assign o_es_valid = i_held_valid && ready_go;
  assign o_fs_ready = ~i_held_valid || (ready_go && i_es_ready);

  assign o_br_taken = o_es_valid && i_es_ready && i_taken;  // only on the fire

endmodule

/* hw/ds_operand_bypass.sv */
// ds_operand_bypass, es/ms/ws priority forwarding mux for one source operand
`timescale 1ns/1ps

module ds_operand_bypass (
  input  ds_pkg::gpr_addr_t i_rs,
  input  ds_pkg::xlen_t     i_rf_data,
  input  ds_pkg::gpr_addr_t i_es_rd,
  input  ds_pkg::gpr_addr_t i_ms_rd,
  input  ds_pkg::gpr_addr_t i_ws_rd,
  input  ds_pkg::xlen_t     i_es_data,
  input  ds_pkg::xlen_t     i_ms_data,
  input  ds_pkg::xlen_t     i_ws_data,
  output ds_pkg::xlen_t     o_data,
  output logic              o_es_hit
);

  import ds_pkg::*;

  logic ms_hit;
  logic ws_hit;

  // rd of zero means the stage forwards nothing
  assign o_es_hit = (i_es_rd != '0) && (i_rs == i_es_rd);
  assign ms_hit   = (i_ms_rd != '0) && (i_rs == i_ms_rd);
  assign ws_hit   = (i_ws_rd != '0) && (i_rs == i_ws_rd);

  assign o_data = o_es_hit ? i_es_data :  // youngest result wins
                  ms_hit   ? i_ms_data :
                  ws_hit   ? i_ws_data :
                             i_rf_data;

endmodule

/* hw/ds_pkg.sv */
// ds_pkg with the word, instruction and register types and the decode enumerations
`include "ds_config.svh"

package ds_pkg;

  typedef logic [`DS_XLEN-1:0] xlen_t;
  typedef logic [`DS_INST_W-1:0] inst_t;
  typedef logic [`DS_GPR_ADDR_W-1:0] gpr_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10  // lui
  } alu_op_e;

  // encodings follow branch funct3
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_func_e;

  typedef enum logic [1:0] {
    JUMP_NONE   = 2'd0,
    JUMP_BRANCH = 2'd1,
    JUMP_JAL    = 2'd2,
    JUMP_JALR   = 2'd3
  } jump_e;

  typedef enum logic {
    SRC1_RS1 = 1'b0,
    SRC1_PC  = 1'b1
  } src1_sel_e;

  typedef enum logic [1:0] {
    SRC2_RS2     = 2'd0,
    SRC2_IMM     = 2'd1,
    SRC2_PC_STEP = 2'd2
  } src2_sel_e;

  // load/store funct3: width in [1:0], unsigned in [2]
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_D  = 3'b011,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101,
    MEM_WU = 3'b110
  } mem_op_e;

endpackage

/* hw/ds_stage_top.sv */
// ds_stage_top, decode stage top level with latch, decoder, register file, bypass and branch
`timescale 1ns/1ps

module ds_stage_top (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_fs_valid,
  output logic              o_fs_ready,
  input  ds_pkg::inst_t     i_fs_inst,
  input  ds_pkg::xlen_t     i_fs_pc,
  output logic              o_es_valid,
  input  logic              i_es_ready,
  output ds_pkg::xlen_t     o_es_pc,
  output ds_pkg::xlen_t     o_es_rs1_data,
  output ds_pkg::xlen_t     o_es_rs2_data,
  output ds_pkg::xlen_t     o_es_imm,
  output ds_pkg::gpr_addr_t o_es_rd,
  output ds_pkg::alu_op_e   o_es_alu_op,
  output ds_pkg::src1_sel_e o_es_src1_sel,
  output ds_pkg::src2_sel_e o_es_src2_sel,
  output logic              o_es_word_op,
  output logic              o_es_gpr_wen,
  output logic              o_es_mem_ren,
  output logic              o_es_mem_wen,
  output ds_pkg::mem_op_e   o_es_mem_op,
  output logic              o_es_load,
  output logic              o_es_invalid,
  input  logic              i_wb_wen,
  input  ds_pkg::gpr_addr_t i_wb_waddr,
  input  ds_pkg::xlen_t     i_wb_wdata,
  input  ds_pkg::gpr_addr_t i_es_byp_rd,
  input  ds_pkg::xlen_t     i_es_byp_data,
  input  ds_pkg::gpr_addr_t i_ms_byp_rd,
  input  ds_pkg::xlen_t     i_ms_byp_data,
  input  ds_pkg::gpr_addr_t i_ws_byp_rd,
  input  ds_pkg::xlen_t     i_ws_byp_data,
  input  logic              i_es_load,
  output logic              o_br_taken,
  output ds_pkg::xlen_t     o_br_target
);

  import ds_pkg::*;

  logic      held_valid;
  inst_t     ds_inst;
  gpr_addr_t rs1;
  gpr_addr_t rs2;
  logic      uses_rs1;
  logic      uses_rs2;
  jump_e     jump;
  br_func_e  br_func;
  xlen_t     rf_rdata1;
  xlen_t     rf_rdata2;
  logic      rs1_es_hit;
  logic      rs2_es_hit;
  logic      taken;  // before the fire qualifier

  assign o_es_load = o_es_mem_ren;

  ds_fetch_latch u_fetch_latch (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_fs_valid   (i_fs_valid),
    .i_fs_ready   (o_fs_ready),
    .i_fs_inst    (i_fs_inst),
    .i_fs_pc      (i_fs_pc),
    .o_held_valid (held_valid),
    .o_inst       (ds_inst),
    .o_pc         (o_es_pc)
  );

  ds_decoder u_decoder (
    .i_inst     (ds_inst),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (o_es_rd),
    .o_uses_rs1 (uses_rs1),
    .o_uses_rs2 (uses_rs2),
    .o_imm      (o_es_imm),
    .o_jump     (jump),
    .o_br_func  (br_func),
    .o_alu_op   (o_es_alu_op),
    .o_src1_sel (o_es_src1_sel),
    .o_src2_sel (o_es_src2_sel),
    .o_word_op  (o_es_word_op),
    .o_gpr_wen  (o_es_gpr_wen),
    .o_mem_ren  (o_es_mem_ren),
    .o_mem_wen  (o_es_mem_wen),
    .o_mem_op   (o_es_mem_op),
    .o_invalid  (o_es_invalid)
  );

  ds_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_wb_wen),
    .i_waddr  (i_wb_waddr),
    .i_wdata  (i_wb_wdata),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2)
  );

  ds_operand_bypass u_rs1_bypass (
    .i_rs      (rs1),
    .i_rf_data (rf_rdata1),
    .i_es_rd   (i_es_byp_rd),
    .i_ms_rd   (i_ms_byp_rd),
    .i_ws_rd   (i_ws_byp_rd),
    .i_es_data (i_es_byp_data),
    .i_ms_data (i_ms_byp_data),
    .i_ws_data (i_ws_byp_data),
    .o_data    (o_es_rs1_data),
    .o_es_hit  (rs1_es_hit)
  );

  ds_operand_bypass u_rs2_bypass (
    .i_rs      (rs2),
    .i_rf_data (rf_rdata2),
    .i_es_rd   (i_es_byp_rd),
    .i_ms_rd   (i_ms_byp_rd),
    .i_ws_rd   (i_ws_byp_rd),
    .i_es_data (i_es_byp_data),
    .i_ms_data (i_ms_byp_data),
    .i_ws_data (i_ws_byp_data),
    .o_data    (o_es_rs2_data),
    .o_es_hit  (rs2_es_hit)
  );

  // compares the forwarded operands
  ds_branch_unit u_branch_unit (
    .i_jump     (jump),
    .i_br_func  (br_func),
    .i_rs1_data (o_es_rs1_data),
    .i_rs2_data (o_es_rs2_data),
    .i_pc       (o_es_pc),
    .i_imm      (o_es_imm),
    .o_taken    (taken),
    .o_target   (o_br_target)
  );

  ds_issue_ctrl u_issue_ctrl (
    .i_held_valid (held_valid),
    .i_es_ready   (i_es_ready),
    .i_es_load    (i_es_load),
    .i_rs1_es_hit (rs1_es_hit),
    .i_rs2_es_hit (rs2_es_hit),
    .i_uses_rs1   (uses_rs1),
    .i_uses_rs2   (uses_rs2),
    .i_taken      (taken),
    .o_fs_ready   (o_fs_ready),
    .o_es_valid   (o_es_valid),
    .o_br_taken   (o_br_taken)
  );

endmodule

/* tests/ds_stage_props.sv */
// ds_stage_props, handshake and hold assertions bound into ds_stage_top
`timescale 1ns/1ps

module ds_stage_props (
  input logic              i_clk,
  input logic              i_reset,
  input logic              i_fs_valid,
  input logic              o_fs_ready,
  input logic              o_es_valid,
  input logic              i_es_ready,
  input logic              o_br_taken,
  input logic              i_held_valid,
  input ds_pkg::xlen_t     o_es_pc,
  input ds_pkg::xlen_t     o_es_rs1_data,
  input ds_pkg::xlen_t     o_es_rs2_data,
  input ds_pkg::xlen_t     o_es_imm,
  input ds_pkg::gpr_addr_t o_es_rd
);

  a_reset_idle: assert property (@(posedge i_clk) i_reset |=> !o_es_valid)
    else $error("es valid high after a reset edge");

  // bundle held while execute is not ready
  a_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    o_es_valid && !i_es_ready |=>
      $stable({o_es_pc, o_es_rs1_data, o_es_rs2_data, o_es_imm, o_es_rd}))
    else $error("es bundle changed under back-pressure");

  a_br_valid: assert property (@(posedge i_clk) disable iff (i_reset)
    o_br_taken |-> o_es_valid)
    else $error("br taken without es valid");

  a_no_accept: assert property (@(posedge i_clk) disable iff (i_reset)
    i_held_valid && !(o_es_valid && i_es_ready) |-> !(i_fs_valid && o_fs_ready))
    else $error("fetch accepted while latch full");

endmodule

bind ds_stage_top ds_stage_props u_props (
  .i_clk         (i_clk),
  .i_reset       (i_reset),
  .i_fs_valid    (i_fs_valid),
  .o_fs_ready    (o_fs_ready),
  .o_es_valid    (o_es_valid),
  .i_es_ready    (i_es_ready),
  .o_br_taken    (o_br_taken),
  .i_held_valid  (held_valid),
  .o_es_pc       (o_es_pc),
  .o_es_rs1_data (o_es_rs1_data),
  .o_es_rs2_data (o_es_rs2_data),
  .o_es_imm      (o_es_imm),
  .o_es_rd       (o_es_rd)
);

/* tests/ds_stage_tb.sv */
// ds_stage_tb, random instruction stream against a decode and forwarding model
`timescale 1ns/1ps
`include "ds_config.svh"

module ds_stage_tb;

  import ds_pkg::*;

  localparam int NUM_INSTR        = 360;
  localparam int CYCLES_PER_INSTR = 12;  // accept, stall and back-pressure worst case
  localparam int TEST_CYCLES      = NUM_INSTR * CYCLES_PER_INSTR + 64;

  typedef struct packed {
    logic [4:0]  rd;
    logic [63:0] imm;
    logic [3:0]  alu;
    logic        s1;
    logic [1:0]  s2;
    logic        word;
    logic        wen;
    logic        ren;
    logic        mwen;
    logic [2:0]  mop;
    logic        inv;
    logic        u1;
    logic        u2;
    logic [1:0]  jump;
  } exp_t;

  logic i_clk, i_reset, i_fs_valid, o_fs_ready, o_es_valid, i_es_ready;
  inst_t i_fs_inst;
  xlen_t i_fs_pc, o_es_pc, o_es_rs1_data, o_es_rs2_data, o_es_imm, o_br_target;
  gpr_addr_t o_es_rd, i_wb_waddr, i_es_byp_rd, i_ms_byp_rd, i_ws_byp_rd;
  alu_op_e o_es_alu_op;
  src1_sel_e o_es_src1_sel;
  src2_sel_e o_es_src2_sel;
  mem_op_e o_es_mem_op;
  logic o_es_word_op, o_es_gpr_wen, o_es_mem_ren, o_es_mem_wen, o_es_load, o_es_invalid;
  logic i_wb_wen, i_es_load, o_br_taken;
  xlen_t i_wb_wdata, i_es_byp_data, i_ms_byp_data, i_ws_byp_data;

  xlen_t model_regs [0:`DS_GPR_NUM-1];
  xlen_t accepted_q [$];
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int stalls = 0;
  int redirects = 0;

  ds_stage_top u_dut (.*);

  always #50 i_clk = ~i_clk;

  initial begin
    #(TEST_CYCLES * 200);
    $display("timeout: the run did not finish within %0d cycles", TEST_CYCLES * 2);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic logic [3:0] alu_code(input logic [2:0] f3, input logic alt,
                                          input logic is_reg);
    case (f3)
      3'd0:    return (is_reg && alt) ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return alt ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // expected decode straight from the RV64I encoding tables
  function automatic exp_t model_decode(input logic [31:0] in);
    exp_t e;
    logic [6:0] op;
    logic [63:0] ii, is, ib, iu, ij;
    e = '0;
    op = in[6:0];
    ii = {{52{in[31]}}, in[31:20]};
    is = {{52{in[31]}}, in[31:25], in[11:7]};
    ib = {{51{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
    iu = {{32{in[31]}}, in[31:12], 12'h000};
    ij = {{43{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
    case (op)
      7'h37: begin
        e.imm = iu;
        e.alu = ALU_PASS_B;
        e.s2 = 2'd1;
        e.wen = 1;
      end
      7'h17: begin
        e.imm = iu;
        e.s1 = 1;
        e.s2 = 2'd1;
        e.wen = 1;
      end
      7'h6f: begin
        e.imm = ij;
        e.jump = 2'd2;
        e.s1 = 1;
        e.s2 = 2'd2;
        e.wen = 1;
      end
      7'h67: begin
        e.imm = ii;
        e.jump = 2'd3;
        e.u1 = 1;
        e.s1 = 1;
        e.s2 = 2'd2;
        e.wen = 1;
      end
      7'h63: begin
        e.imm = ib;
        e.jump = 2'd1;
        e.u1 = 1;
        e.u2 = 1;
      end
      7'h03: begin
        e.imm = ii;
        e.u1 = 1;
        e.s2 = 2'd1;
        e.wen = 1;
        e.ren = 1;
      end
      7'h23: begin
        e.imm = is;
        e.u1 = 1;
        e.u2 = 1;
        e.s2 = 2'd1;
        e.mwen = 1;
      end
      7'h13, 7'h1b: begin
        e.imm = ii;
        e.u1 = 1;
        e.s2 = 2'd1;
        e.wen = 1;
        e.word = (op == 7'h1b);
        e.alu = alu_code(in[14:12], in[30], 1'b0);
      end
      7'h33, 7'h3b: begin
        e.u1 = 1;
        e.u2 = 1;
        e.wen = 1;
        e.word = (op == 7'h3b);
        e.alu = alu_code(in[14:12], in[30], 1'b1);
      end
      default: e.inv = 1;
    endcase
    e.rd = e.wen ? in[11:7] : 5'd0;
    e.mop = in[14:12];
    return e;
  endfunction

  function automatic logic [63:0] forward(input logic [4:0] rs);
    if (i_es_byp_rd != 0 && rs == i_es_byp_rd) return i_es_byp_data;
    if (i_ms_byp_rd != 0 && rs == i_ms_byp_rd) return i_ms_byp_data;
    if (i_ws_byp_rd != 0 && rs == i_ws_byp_rd) return i_ws_byp_data;
    return (rs == 0) ? 64'd0 : model_regs[rs];
  endfunction

  function automatic logic branch_taken(input exp_t e, input logic [2:0] f3,
                                        input logic [63:0] a, input logic [63:0] b);
    if (e.jump == 2'd2 || e.jump == 2'd3) return 1'b1;
    if (e.jump != 2'd1) return 1'b0;
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] gen_inst();
    logic [6:0] ops [12] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23,
                             7'h13, 7'h1b, 7'h33, 7'h3b, 7'h73};
    logic [31:0] in;
    in = $urandom;
    in[6:0] = ops[$urandom % 12];  // 7'h73 is outside the kept set
    return in;
  endfunction

  function automatic logic [4:0] pick_rd(input logic [31:0] in);
    case ($urandom % 4)
      0:       return in[19:15];
      1:       return in[24:20];
      2:       return 5'd0;
      default: return $urandom;
    endcase
  endfunction

  task automatic check_bundle(input exp_t e, input logic [63:0] pc,
                              input logic [63:0] a, input logic [63:0] b);
    check(o_es_pc, pc, "es pc");
    check(o_es_rd, e.rd, "es rd");
    check(o_es_imm, e.imm, "es imm");
    check(o_es_alu_op, e.alu, "es alu op");
    check(o_es_src1_sel, e.s1, "es src1 sel");
    check(o_es_src2_sel, e.s2, "es src2 sel");
    check({o_es_word_op, o_es_gpr_wen}, {e.word, e.wen}, "es word op and gpr wen");
    check({o_es_mem_ren, o_es_mem_wen, o_es_load}, {e.ren, e.mwen, e.ren}, "es mem controls");
    check(o_es_mem_op, e.mop, "es mem op");
    check(o_es_invalid, e.inv, "es invalid");
    check(o_es_rs1_data, a, "es rs1 data");
    check(o_es_rs2_data, b, "es rs2 data");
  endtask

  // mode 0 no bypass, 1 random bypass, 2 bypass with frequent loads
  task automatic run_instr(input int mode);
    logic [31:0] in;
    logic [63:0] pc, a, b, tgt, qpc;
    exp_t e;
    logic stall, taken, fired;
    int waits;
    in = gen_inst();
    pc = rand64();
    pc[1:0] = 2'b00;
    i_fs_valid = 1;
    i_fs_inst = in;
    i_fs_pc = pc;
    if ($urandom % 2) begin
      i_wb_wen = 1;
      i_wb_waddr = $urandom;
      i_wb_wdata = rand64();
    end
    #10;
    check(o_fs_ready, 1, "fs ready with empty latch");
    check(o_es_valid, 0, "es valid with empty latch");
    @(posedge i_clk);
    if (i_wb_wen && i_wb_waddr != 0) model_regs[i_wb_waddr] = i_wb_wdata;
    accepted_q.push_back(pc);
    #1;
    i_fs_valid = 0;
    i_wb_wen = 0;
    if (mode > 0) begin
      i_es_byp_rd = pick_rd(in);
      i_ms_byp_rd = pick_rd(in);
      i_ws_byp_rd = pick_rd(in);
      i_es_byp_data = rand64();
      i_ms_byp_data = rand64();
      i_ws_byp_data = rand64();
      i_es_load = (mode == 2) ? ($urandom % 2) : ($urandom % 4 == 0);
    end
    i_es_ready = $urandom % 2;
    e = model_decode(in);
    a = forward(in[19:15]);
    b = forward(in[24:20]);
    stall = i_es_load && i_es_byp_rd != 0 &&
            ((e.u1 && in[19:15] == i_es_byp_rd) || (e.u2 && in[24:20] == i_es_byp_rd));
    if (stall) begin
      stalls++;
      repeat (2) begin
        #10;
        check(o_es_valid, 0, "es valid during load-use stall");
        check(o_fs_ready, 0, "fs ready during load-use stall");
        check(o_br_taken, 0, "br taken during load-use stall");
        @(posedge i_clk);
        #1;
      end
      i_es_load = 0;
    end
    taken = branch_taken(e, in[14:12], a, b);
    tgt = (e.jump == 2'd3) ? ((a + e.imm) & ~64'd1) : (pc + e.imm);
    fired = 0;
    waits = 0;
    while (!fired) begin
      if (waits >= 4) i_es_ready = 1;
      #10;
      check(o_es_valid, 1, "es valid for held instruction");
      check_bundle(e, pc, a, b);
      if (i_es_ready) begin
        qpc = accepted_q.pop_front();
        check(o_es_pc, qpc, "issue order");
        check(o_br_taken, taken, "br taken on fire");
        if (e.jump != 2'd0) check(o_br_target, tgt, "br target on fire");
        redirects += taken;
        fired = 1;
      end else begin
        check(o_fs_ready, 0, "fs ready under back-pressure");
        check(o_br_taken, 0, "br taken without fire");
      end
      @(posedge i_clk);
      #1;
      if (!fired) i_es_ready = $urandom % 2;
      waits++;
    end
  endtask

  task automatic run_stream(input string name, input int mode, input int count);
    int err_start;
    err_start = errors;
    repeat (count) run_instr(mode);
    tests++;
    $display("test %s: %0d instructions, %0d errors", name, count, errors - err_start);
  endtask

  initial begin
    void'($urandom(32'hbaac48ee));
    i_clk = 0;
    i_reset = 1;
    i_fs_valid = 0;
    i_fs_inst = '0;
    i_fs_pc = '0;
    i_es_ready = 0;
    i_wb_wen = 0;
    i_wb_waddr = '0;
    i_wb_wdata = '0;
    i_es_byp_rd = '0;
    i_ms_byp_rd = '0;
    i_ws_byp_rd = '0;
    i_es_byp_data = '0;
    i_ms_byp_data = '0;
    i_ws_byp_data = '0;
    i_es_load = 0;
    repeat (5) begin
      @(posedge i_clk);
      #10;
      check({o_es_valid, o_br_taken, o_fs_ready}, 3'b001, "handshakes in reset");
    end
    i_reset = 0;
    #10;
    check({o_es_valid, o_br_taken, o_fs_ready}, 3'b001, "handshakes after reset");
    tests++;
    $display("test reset: %0d errors", errors);
    model_regs[0] = '0;
    for (int r = 0; r < `DS_GPR_NUM; r++) begin  // x0 write must be dropped
      @(posedge i_clk);
      #1;
      i_wb_wen = 1;
      i_wb_waddr = r;
      i_wb_wdata = rand64();
      if (r != 0) model_regs[r] = i_wb_wdata;
    end
    @(posedge i_clk);
    #1;
    i_wb_wen = 0;
    run_stream("decode", 0, 100);
    run_stream("forwarding", 1, 140);
    run_stream("load_use", 2, 120);
    $display("summary: %0d tests, %0d checks, %0d stalls, %0d redirects, %0d errors",
             tests, checks, stalls, redirects, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hw
hw/ds_pkg.sv
hw/ds_fetch_latch.sv
hw/ds_decoder.sv
hw/ds_gpr_file.sv
hw/ds_operand_bypass.sv
hw/ds_branch_unit.sv
hw/ds_issue_ctrl.sv
hw/ds_stage_top.sv
tests/ds_stage_props.sv
tests/ds_stage_tb.sv
